//--- verilog/xt_kbd_pkg.sv
// shared constants for the XT keyboard adapter; scan codes are 8 bits, set 2 in, set 1 out
package xt_kbd_pkg;

	// one scan code, also the width of the host port pa
	localparam int code_w = 8;

	// falling kbd_clk edges per frame
	// start, eight data bits, parity and stop
	localparam int frame_bits = 11;

	// set 2 break prefix, comes before the code of a released key
	localparam logic [code_w-1:0] break_prefix = 8'hf0;

	// reported to the host at the end of a keyboard reset
	localparam logic [code_w-1:0] self_test_ok = 8'haa;

	// set in pa for a released key (XT break code)
	localparam int break_flag_bit = 7;

	// host port FSM
	typedef enum logic [2:0] {
		st_idle,      // waiting for a code
		st_prefix,    // break prefix seen
		st_irq,       // code on pa, irq1 high
		st_ack,       // host saw pb7 high, waiting for pb7 low
		st_kbd_reset, // pb6 held low
		st_reset_ack  // pb6 back high, waiting for pb7 low
	} host_state_e;

	// the host port moves through these in order for one key:
	//   st_idle -> st_irq -> st_ack -> st_idle
	// and for a released key:
	//   st_idle -> st_prefix -> st_irq -> st_ack -> st_idle
	// a keyboard reset ends with self_test_ok in st_irq

endpackage

//--- verilog/ps2_frame_rx.sv
// receive only; kbd_clk and kbd_data are sampled in the clk domain, parity and stop not checked
`timescale 1ns/1ps

module ps2_frame_rx
	import xt_kbd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              kbd_clk,
	input  logic              kbd_data,
	output logic [code_w-1:0] raw_code,
	output logic              raw_valid
);

	logic [1:0] clk_sync;  // two-flop synchronizer
	logic [1:0] data_sync;
	logic       clk_prev;
	logic       clk_fall;
	logic [$clog2(frame_bits)-1:0] bit_cnt; // falling edges seen in this frame

	// both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], kbd_clk};
			data_sync <= {data_sync[0], kbd_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt   <= '0;
			raw_valid <= 1'b0;
		end else begin
			raw_valid <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == frame_bits - 1) begin
					bit_cnt   <= '0;
					raw_valid <= 1'b1; // stop bit, code complete
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// bit 0 is the start bit, then data lsb first; parity falls through
	always_ff @(posedge clk) begin
		if (clk_fall && bit_cnt >= 1 && bit_cnt <= code_w)
			raw_code <= {data_sync[1], raw_code[code_w-1:1]};
	end

	// counter must wrap on the stop bit, never run past the frame
	a_bit_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		bit_cnt < frame_bits);

endmodule

//--- verilog/scan_code_xlat.sv
// set 2 to XT set 1 for 0x00-0x7f plus 0x83/0x84; all other codes pass through unchanged
`timescale 1ns/1ps

module scan_code_xlat
	import xt_kbd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [code_w-1:0] raw_code,
	input  logic              raw_valid,
	output logic [code_w-1:0] xt_code,
	output logic              xt_valid
);

	// set 1 value for set 2 codes 0x00 to 0x7f, eight per row
	localparam logic [code_w-1:0] set1_tab [0:127] = '{
		8'hff, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58, // 0x00
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a, // 0x10
		8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,
		8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c, // 0x20
		8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e, // 0x30
		8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,
		8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60, // 0x40
		8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,
		8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e, // 0x50
		8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b, // 0x60
		8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,
		8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45, // 0x70
		8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54
	};

	logic [code_w-1:0] xlat_code;

	always_comb begin
		if (!raw_code[code_w-1]) begin
			xlat_code = set1_tab[raw_code[code_w-2:0]];
		end else if (raw_code == 8'h83) begin
			xlat_code = 8'h41; // F7 sits outside the main block
		end else if (raw_code == 8'h84) begin
			xlat_code = 8'h54; // alt sysrq
		end else begin
			xlat_code = raw_code; // includes the f0 prefix
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			xt_valid <= 1'b0;
		else
			xt_valid <= raw_valid;
	end

	// code only moves with a valid frame
	always_ff @(posedge clk) begin
		if (raw_valid)
			xt_code <= xlat_code;
	end

endmodule

//--- verilog/xt_host_port.sv
// one code in flight; codes that arrive while irq1 is up or pb7 is high are dropped
`timescale 1ns/1ps

module xt_host_port
	import xt_kbd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [code_w-1:0] xt_code,
	input  logic              xt_valid,
	input  logic              pb6,
	input  logic              pb7,
	output logic [code_w-1:0] pa,
	output logic              irq1
);

	host_state_e state;
	host_state_e state_next;
	logic        take_code; // a code the port can accept now

	// host still acknowledging the last one when pb7 is high
	assign take_code = xt_valid & ~pb7;

	always_comb begin
		state_next = state;
		if (!pb6 && state != st_kbd_reset) begin
			state_next = st_kbd_reset; // keyboard reset wins over everything
		end else begin
			case (state)
				st_idle, st_prefix: begin
					if (take_code)
						state_next = (xt_code == break_prefix) ? st_prefix : st_irq;
				end
				st_irq: begin
					if (pb7)
						state_next = st_ack;
				end
				st_ack: begin
					if (!pb7)
						state_next = st_idle;
				end
				st_kbd_reset: begin
					if (pb6)
						state_next = st_reset_ack;
				end
				st_reset_ack: begin
					if (!pb7)
						state_next = st_irq;
				end
				default: state_next = st_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pa    <= '0;
			irq1  <= 1'b0;
		end else begin
			state <= state_next;
			irq1  <= (state_next == st_irq);
			if (state == st_idle && state_next == st_irq) begin
				pa <= xt_code;
			end else if (state == st_prefix && state_next == st_irq) begin
				pa <= xt_code;
				pa[break_flag_bit] <= 1'b1; // released key
			end else if (state == st_reset_ack && state_next == st_irq) begin
				pa <= self_test_ok;
			end else if (state == st_ack && state_next == st_idle) begin
				pa <= '0;
			end
		end
	end

	// acknowledge drops the interrupt on the next edge
	a_ack_drops_irq: assert property (@(posedge clk) disable iff (!rst_n)
		pb7 |=> !irq1);

	// pa holds while the interrupt waits for the host
	a_pa_held: assert property (@(posedge clk) disable iff (!rst_n)
		$past(irq1) && irq1 |-> $stable(pa));

endmodule

//--- verilog/xt_keyboard.sv
// PS/2 keyboard to XT host port; keyboard lines are inputs only, no host-to-keyboard commands
`timescale 1ns/1ps

module xt_keyboard
	import xt_kbd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              kbd_clk,
	input  logic              kbd_data,
	input  logic              pb6,
	input  logic              pb7,
	output logic [code_w-1:0] pa,
	output logic              irq1
);

	logic [code_w-1:0] raw_code; // set 2, straight off the wire
	logic              raw_valid;
	logic [code_w-1:0] xt_code;  // set 1
	logic              xt_valid;

	ps2_frame_rx i_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.kbd_clk   (kbd_clk),
		.kbd_data  (kbd_data),
		.raw_code  (raw_code),
		.raw_valid (raw_valid)
	);

	scan_code_xlat i_xlat (
		.clk       (clk),
		.rst_n     (rst_n),
		.raw_code  (raw_code),
		.raw_valid (raw_valid),
		.xt_code   (xt_code),
		.xt_valid  (xt_valid)
	);

	xt_host_port i_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.xt_code  (xt_code),
		.xt_valid (xt_valid),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

endmodule

//--- verification/xt_keyboard_tb.sv
// reads verification/xt_kbd_stim.txt from the project root; opcode D (two F0 prefixes) extends K/B/R/O
`timescale 1ns/1ps

module xt_keyboard_tb;

	localparam int clk_period   = 20;
	localparam int ps2_half     = 10;   // clk cycles per half kbd_clk period
	localparam int ack_len      = 4;    // pb7 high time, clk cycles
	localparam int irq_wait_max = 400;  // clk cycles allowed for irq1 to rise
	localparam int frame_cycles = 11 * 2 * ps2_half;
	localparam int test_ns      = 30000;
	localparam int max_tests    = 64;
	localparam int unsigned seed = 32'h3ac4;
	localparam logic [7:0] overrun_code = 8'h29;

	logic       clk;
	logic       rst_n;
	logic       kbd_clk;
	logic       kbd_data;
	logic       pb6;
	logic       pb7;
	logic [7:0] pa;
	logic       irq1;

	logic [7:0]  op_tab   [0:max_tests-1];
	logic [7:0]  code_tab [0:max_tests-1];
	logic [7:0]  exp_tab  [0:max_tests-1];
	int          n_tests;
	int          err_cnt;
	int          n_pass;
	int          n_fail;
	logic        stim_loaded;

	xt_keyboard i_xt_keyboard (
		.clk      (clk),
		.rst_n    (rst_n),
		.kbd_clk  (kbd_clk),
		.kbd_data (kbd_data),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// lands 2 ns after a rising edge, where inputs change and outputs are read
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp) else begin
			$display("ERR %0t %s expected %02h actual %02h", $time, name, exp, act);
			err_cnt++;
		end
	endtask

	// start, data lsb first, odd parity, stop
	task automatic send_frame(input logic [7:0] code);
		logic [10:0] bits;
		bits = {1'b1, ~^code, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			kbd_data = bits[i]; // data moves while kbd_clk is high
			step(ps2_half);
			kbd_clk = 1'b0;
			step(ps2_half);
			kbd_clk = 1'b1;
		end
		step(ps2_half);
	endtask

	task automatic wait_irq(output logic seen);
		int n;
		n = 0;
		while (irq1 !== 1'b1 && n < irq_wait_max) begin
			step(1);
			n++;
		end
		seen = (irq1 === 1'b1);
		assert (seen) else begin
			$display("irq1 did not rise within %0d cycles, at %0t", irq_wait_max, $time);
			err_cnt++;
		end
	endtask

	task automatic acknowledge();
		pb7 = 1'b1;
		step(ack_len);
		check_value("irq1", 8'h00, {7'b0, irq1});
		pb7 = 1'b0;
		step(2);
		check_value("pa", 8'h00, pa); // cleared once pb7 is low again
	endtask

	task automatic expect_code(input logic [7:0] exp);
		logic seen;
		wait_irq(seen);
		if (seen) begin
			check_value("pa", exp, pa);
			acknowledge();
		end
	endtask

	task automatic expect_no_irq(input int n, input string what);
		logic rose;
		rose = 1'b0;
		repeat (n) begin
			step(1);
			if (irq1 !== 1'b0)
				rose = 1'b1;
		end
		assert (!rose) else begin
			$display("irq1 went high %s, at %0t", what, $time);
			err_cnt++;
		end
	endtask

	task automatic load_stim();
		int         fd;
		int         n;
		string      line;
		logic [7:0] op;
		logic [7:0] code;
		logic [7:0] exp;
		fd = $fopen("verification/xt_kbd_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verification/xt_kbd_stim.txt");
			err_cnt++;
		end else begin
			while (!$feof(fd) && n_tests < max_tests) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h", op, code, exp);
					if (n == 3) begin
						op_tab[n_tests]   = op;
						code_tab[n_tests] = code;
						exp_tab[n_tests]  = exp;
						n_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int idx);
		logic [7:0] op;
		logic [7:0] code;
		logic [7:0] exp;
		logic       seen;
		int         errs_before;
		op = op_tab[idx];
		code = code_tab[idx];
		exp = exp_tab[idx];
		errs_before = err_cnt;
		step(20 + ($urandom % 64)); // idle gap between frames
		case (op)
			"K": begin
				send_frame(code);
				expect_code(exp);
			end
			"B", "D": begin
				send_frame(8'hf0);
				if (op == "D")
					send_frame(8'hf0);
				expect_no_irq(4, "after a break prefix");
				send_frame(code);
				expect_code(exp);
			end
			"R": begin
				pb6 = 1'b0;
				expect_no_irq(8, "while pb6 is low");
				pb6 = 1'b1;
				expect_code(exp); // self-test result
			end
			"O": begin
				send_frame(code);
				wait_irq(seen);
				if (seen) begin
					check_value("pa", exp, pa);
					send_frame(overrun_code); // port busy, this one is lost
					check_value("pa", exp, pa);
					check_value("irq1", 8'h01, {7'b0, irq1});
					acknowledge();
					expect_no_irq(frame_cycles, "after the overrun acknowledge");
				end
			end
			default: begin
				$display("unknown opcode %c in stimulus line %0d", op, idx);
				err_cnt++;
			end
		endcase
		if (err_cnt == errs_before) begin
			n_pass++;
			$display("test %0d %c %02h -> %02h ok", idx, op, code, exp);
		end else begin
			n_fail++;
			$display("test %0d %c %02h -> %02h failed", idx, op, code, exp);
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		kbd_clk     = 1'b1; // both PS/2 lines idle high
		kbd_data    = 1'b1;
		pb6         = 1'b1;
		pb7         = 1'b0;
		n_tests     = 0;
		err_cnt     = 0;
		n_pass      = 0;
		n_fail      = 0;
		stim_loaded = 1'b0;
		void'($urandom(seed));
		load_stim();
		stim_loaded = 1'b1;
		step(16);
		rst_n = 1'b1;
		step(2);
		check_value("pa", 8'h00, pa);
		check_value("irq1", 8'h00, {7'b0, irq1});
		$display("reset values %s", (err_cnt == 0) ? "ok" : "failed");
		for (int i = 0; i < n_tests; i++)
			run_test(i);
		if (n_tests == 0) begin
			$display("no tests found in the stimulus file");
			err_cnt++;
		end
		$display("tests %0d passed %0d failed %0d errors %0d", n_tests, n_pass, n_fail, err_cnt);
		if (err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog, 30 us per test plus the reset time
	initial begin
		wait (stim_loaded);
		#(n_tests * test_ns + 16 * clk_period);
		$display("watchdog expired before all tests finished");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- verification/xt_kbd_stim.txt
# op code pa: K key, B F0 then code, D two F0 then code, R keyboard reset, O overrun
# code is the set 2 byte in hex, pa the expected set 1 value on the host port in hex
K 1c 1e
K 1d 11
K 16 02
K 5a 1c
K 29 39
K 76 01
K 05 3b
K 66 0e
K 83 41
K 84 54
K b5 b5
K e0 e0
K 0d 0f
B 1c 9e
B 29 b9
B 76 81
B 11 b8
D 1c 9e
D 5a 9c
R 00 aa
O 1c 1e
O 66 0e
K 11 38
R 00 aa

//--- sim.f
verilog/xt_kbd_pkg.sv
verilog/ps2_frame_rx.sv
verilog/scan_code_xlat.sv
verilog/xt_host_port.sv
verilog/xt_keyboard.sv
verification/xt_keyboard_tb.sv

//--- Bender.yml
package:
  name: xt_keyboard

dependencies: {}

sources:
  # package first, then the RTL in dependency order
  - files:
      - verilog/xt_kbd_pkg.sv
      - verilog/ps2_frame_rx.sv
      - verilog/scan_code_xlat.sv
      - verilog/xt_host_port.sv
      - verilog/xt_keyboard.sv

  - target: test
    files:
      - verification/xt_keyboard_tb.sv
